/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_versat_mem_port
FILELIST  := versat_mem_port.f
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* rtl/axi_burst_master.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_burst_master import databus_pkg::*, axi_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      wr_valid,
  output logic      wr_ready,
  output logic      wr_last,
  input  db_req_t   wr_req,
  input  logic      rd_valid,
  output logic      rd_ready,
  output logic      rd_last,
  input  db_req_t   rd_req,
  output axi_addr_t aw,
  output logic      aw_valid,
  input  logic      aw_ready,
  output axi_addr_t ar,
  output logic      ar_valid,
  input  logic      ar_ready,
  output axi_w_t    w_beat,
  output logic      w_valid,
  input  logic      w_ready,
  input  axi_r_t    r_beat,
  input  logic      r_valid,
  output logic      r_ready,
  input  logic      b_valid,
  output logic      b_ready
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WR_ADDR,
    S_WR_DATA,
    S_RD_ADDR,
    S_RD_DATA
  } state_t;

  state_t           state;
  logic [LEN_W-1:0] beat_cnt;      // W beats handed to the slice
  logic             b_wait;        // Write still open until its response
  logic             w_end;

  assign b_ready = 1'b1;           // Response accepted, code ignored

  // Beats pass straight between the channel and the slices
  always_comb begin
    w_valid     = (state == S_WR_DATA) && wr_valid;
    wr_ready    = (state == S_WR_DATA) && w_ready;
    w_beat.data = wr_req.wdata;
    w_beat.strb = wr_req.wstrb;
    w_beat.last = (beat_cnt == wr_req.len);
    wr_last     = wr_ready && w_beat.last;
    r_ready     = (state == S_RD_DATA) && rd_valid;
    rd_ready    = (state == S_RD_DATA) && r_valid;
    rd_last     = rd_ready && r_beat.last;
  end

  assign w_end = w_valid && w_ready && w_beat.last;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= S_IDLE;
      aw_valid <= 1'b0;
      ar_valid <= 1'b0;
      beat_cnt <= '0;
      b_wait   <= 1'b0;
    end else begin
      if (w_end) begin
        b_wait <= 1'b1;
      end else if (b_valid) begin
        b_wait <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          if (!b_wait && wr_valid) begin   // Write wins a tie
            aw_valid <= 1'b1;
            state    <= S_WR_ADDR;
          end else if (!b_wait && rd_valid) begin
            ar_valid <= 1'b1;
            state    <= S_RD_ADDR;
          end
        end
        S_WR_ADDR: begin
          if (aw_ready) begin
            aw_valid <= 1'b0;
            state    <= S_WR_DATA;
          end
        end
        S_WR_DATA: begin
          if (w_end) begin
            beat_cnt <= '0;
            state    <= S_IDLE;
          end else if (w_valid && w_ready) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        S_RD_ADDR: begin
          if (ar_ready) begin
            ar_valid <= 1'b0;
            state    <= S_RD_DATA;
          end
        end
        S_RD_DATA: begin
          if (r_valid && r_ready && r_beat.last) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Address payload follows the channel while idle, frozen after
  always_ff @(posedge clk) begin
    if (state == S_IDLE) begin
      aw.addr <= wr_req.addr;
      aw.len  <= wr_req.len;
      ar.addr <= rd_req.addr;
      ar.len  <= rd_req.len;
    end
  end

  a_one_addr: assert property (@(posedge clk) disable iff (rst)
    !(aw_valid && ar_valid));
  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    aw_valid && !aw_ready |=> aw_valid);
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    ar_valid && !ar_ready |=> ar_valid);

endmodule

`default_nettype wire

/* rtl/axi_pkg.sv */
`default_nettype none

// AXI4 subset seen by the memory slave
// Burst is always INCR and size is fixed, so neither field travels
package axi_pkg;

  import databus_pkg::*;

  localparam int AXI_SIZE_BYTES = 4;  // Bytes per beat, address step of INCR

  // Shared by AW and AR
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;           // Beats minus one
  } axi_addr_t;

  // Write beat
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  // Read beat, response code not carried
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } axi_r_t;

endpackage

`default_nettype wire

/* rtl/databus_merge.sv */
`timescale 1ns/100ps
`default_nettype none

module databus_merge import databus_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  db_req_t [N_PORTS-1:0]  req,
  output logic [N_PORTS-1:0]     port_ready,
  output logic [N_PORTS-1:0]     port_last,
  output logic                   wr_valid,
  input  logic                   wr_ready,
  input  logic                   wr_last,
  output db_req_t                wr_req,
  output logic                   rd_valid,
  input  logic                   rd_ready,
  input  logic                   rd_last,
  output db_req_t                rd_req
);

  logic              wr_any;
  logic              rd_any;
  logic [PORT_W-1:0] wr_pick;
  logic [PORT_W-1:0] rd_pick;
  logic              wr_busy;      // Write channel granted
  logic              rd_busy;
  logic [PORT_W-1:0] wr_sel;
  logic [PORT_W-1:0] rd_sel;

  // Highest-numbered requester of each kind wins, later index overrides
  always_comb begin
    wr_any  = 1'b0;
    rd_any  = 1'b0;
    wr_pick = '0;
    rd_pick = '0;
    for (int i = 0; i < N_PORTS; i++) begin
      if (req[i].valid) begin
        if (|req[i].wstrb) begin
          wr_any  = 1'b1;
          wr_pick = PORT_W'(i);
        end else begin
          rd_any  = 1'b1;
          rd_pick = PORT_W'(i);
        end
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_busy <= 1'b0;
      rd_busy <= 1'b0;
      wr_sel  <= '0;
      rd_sel  <= '0;
    end else begin
      if (!wr_busy && wr_any) begin
        wr_busy <= 1'b1;
        wr_sel  <= wr_pick;
      end else if (wr_busy && wr_valid && wr_ready && wr_last) begin
        wr_busy <= 1'b0;             // Final beat taken
      end
      if (!rd_busy && rd_any) begin
        rd_busy <= 1'b1;
        rd_sel  <= rd_pick;
      end else if (rd_busy && rd_valid && rd_ready && rd_last) begin
        rd_busy <= 1'b0;
      end
    end
  end

  // Steer the granted request down, beat status back up
  always_comb begin
    wr_valid   = wr_busy && req[wr_sel].valid;
    rd_valid   = rd_busy && req[rd_sel].valid;
    wr_req     = wr_busy ? req[wr_sel] : '0;
    rd_req     = rd_busy ? req[rd_sel] : '0;
    port_ready = '0;
    port_last  = '0;
    if (wr_busy) begin
      port_ready[wr_sel] = wr_ready;
      port_last[wr_sel]  = wr_last;
    end
    if (rd_busy) begin
      port_ready[rd_sel] = port_ready[rd_sel] | rd_ready;
      port_last[rd_sel]  = port_last[rd_sel] | rd_last;
    end
  end

  a_wr_grant_held: assert property (@(posedge clk) disable iff (rst)
    wr_busy && $past(wr_busy) |-> $stable(wr_sel));
  a_rd_grant_held: assert property (@(posedge clk) disable iff (rst)
    rd_busy && $past(rd_busy) |-> $stable(rd_sel));
  // Burst master only flags last on a beat that moves
  a_last_with_ready: assert property (@(posedge clk) disable iff (rst)
    (port_last & ~port_ready) == '0);

endmodule

`default_nettype wire

/* rtl/databus_pkg.sv */
`default_nettype none

// Internal data-bus side of the memory path
package databus_pkg;

  localparam int N_PORTS = 4;         // Units sharing the memory path
  localparam int ADDR_W  = 32;        // Byte address
  localparam int DATA_W  = 32;
  localparam int STRB_W  = DATA_W / 8;
  localparam int LEN_W   = 8;         // Beats minus one, same as AXI4 len

  // Index of one data-bus port
  localparam int PORT_W  = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

  // Request of one unit
  // addr, len and wstrb stay steady while valid is high for the burst,
  // wdata follows the current beat. A zero wstrb marks a read
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic [LEN_W-1:0]  len;
  } db_req_t;

endpackage

`default_nettype wire

/* rtl/skid_slice.sv */
`timescale 1ns/100ps
`default_nettype none

// Main register drives the output, spare catches the beat that was
// in flight when the output stalled
module skid_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,       // Low exactly while the spare is full
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t spare_data;
  logic     main_load;             // Main free or draining this cycle
  logic     take_spare;
  logic     take_in;
  logic     park;

  always_comb begin
    main_load  = !out_valid || out_ready;
    take_spare = main_load && !in_ready;
    take_in    = main_load && in_ready && in_valid;
    park       = !main_load && in_valid && in_ready;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
      in_ready  <= 1'b1;
    end else if (main_load) begin
      out_valid <= !in_ready || in_valid;
      in_ready  <= 1'b1;           // Spare empties into main
    end else if (park) begin
      in_ready  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take_spare) begin
      out_data <= spare_data;      // Oldest beat first
    end else if (take_in) begin
      out_data <= in_data;
    end
    if (park) begin
      spare_data <= in_data;
    end
  end

  // Both entries full under a stall means neither register changes
  a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
    out_valid && !in_ready && !out_ready |=> !in_ready && $stable(out_data));

endmodule

`default_nettype wire

/* rtl/versat_mem_port.sv */
`timescale 1ns/100ps
`default_nettype none

module versat_mem_port import databus_pkg::*, axi_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  db_req_t [N_PORTS-1:0] req,
  output logic [N_PORTS-1:0]    port_ready,
  output logic [N_PORTS-1:0]    port_last,
  output logic [DATA_W-1:0]     rdata,
  output axi_addr_t             aw,
  output logic                  aw_valid,
  input  logic                  aw_ready,
  output axi_addr_t             ar,
  output logic                  ar_valid,
  input  logic                  ar_ready,
  output axi_w_t                w,
  output logic                  w_valid,
  input  logic                  w_ready,
  input  axi_r_t                r,
  input  logic                  r_valid,
  output logic                  r_ready,
  input  logic                  b_valid,
  output logic                  b_ready
);

  logic    wr_valid;
  logic    wr_ready;
  logic    wr_last;
  db_req_t wr_req;
  logic    rd_valid;
  logic    rd_ready;
  logic    rd_last;
  db_req_t rd_req;
  axi_w_t  w_mid;                  // Burst master to W slice
  logic    w_mid_valid;
  logic    w_mid_ready;
  axi_r_t  r_mid;                  // R slice to burst master
  logic    r_mid_valid;
  logic    r_mid_ready;

  assign rdata = r_mid.data;       // Shared by all ports

  databus_merge merge (
    .clk(clk), .rst(rst), .req(req),
    .port_ready(port_ready), .port_last(port_last),
    .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_last(wr_last), .wr_req(wr_req),
    .rd_valid(rd_valid), .rd_ready(rd_ready), .rd_last(rd_last), .rd_req(rd_req)
  );

  axi_burst_master master (
    .clk(clk), .rst(rst),
    .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_last(wr_last), .wr_req(wr_req),
    .rd_valid(rd_valid), .rd_ready(rd_ready), .rd_last(rd_last), .rd_req(rd_req),
    .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .w_beat(w_mid), .w_valid(w_mid_valid), .w_ready(w_mid_ready),
    .r_beat(r_mid), .r_valid(r_mid_valid), .r_ready(r_mid_ready),
    .b_valid(b_valid), .b_ready(b_ready)
  );

  skid_slice #(.payload_t(axi_w_t)) w_slice (
    .clk(clk), .rst(rst),
    .in_data(w_mid), .in_valid(w_mid_valid), .in_ready(w_mid_ready),
    .out_data(w), .out_valid(w_valid), .out_ready(w_ready)
  );

  skid_slice #(.payload_t(axi_r_t)) r_slice (
    .clk(clk), .rst(rst),
    .in_data(r), .in_valid(r_valid), .in_ready(r_ready),
    .out_data(r_mid), .out_valid(r_mid_valid), .out_ready(r_mid_ready)
  );

endmodule

`default_nettype wire

/* sim/axi_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

// AXI slave memory, one burst at a time, random stalls on its own handshakes
module axi_mem_model import databus_pkg::*, axi_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  axi_addr_t aw,
  input  logic      aw_valid,
  output logic      aw_ready,
  input  axi_addr_t ar,
  input  logic      ar_valid,
  output logic      ar_ready,
  input  axi_w_t    w,
  input  logic      w_valid,
  output logic      w_ready,
  output axi_r_t    r,
  output logic      r_valid,
  input  logic      r_ready,
  output logic      b_valid,
  input  logic      b_ready
);

  logic [DATA_W-1:0] mem [int];
  int                phase;        // 0 idle, 1 write data, 2 read data
  int                waddr;
  int                raddr;
  int                rcnt;         // Read beats left after the current one

  function automatic logic go();
    return ($urandom % 4) != 0;    // Stall about one cycle in four
  endfunction

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      aw_ready <= 1'b0;
      ar_ready <= 1'b0;
      w_ready  <= 1'b0;
      r_valid  <= 1'b0;
      r        <= '0;
      b_valid  <= 1'b0;
      phase    <= 0;
    end else begin
      aw_ready <= 1'b0;
      ar_ready <= 1'b0;
      b_valid  <= 1'b0;
      case (phase)
        0: begin
          if (aw_valid && aw_ready) begin
            waddr   <= int'(aw.addr);
            phase   <= 1;
            w_ready <= go();
          end else if (ar_valid && ar_ready) begin
            raddr <= int'(ar.addr);
            rcnt  <= int'(ar.len);
            phase <= 2;
          end else begin
            aw_ready <= go();
            ar_ready <= go();
          end
        end
        1: begin
          w_ready <= go();
          if (w_valid && w_ready) begin
            mem[waddr / AXI_SIZE_BYTES] = w.data;
            waddr <= waddr + AXI_SIZE_BYTES;
            if (w.last) begin
              phase   <= 0;
              w_ready <= 1'b0;
              b_valid <= 1'b1;
            end
          end
        end
        2: begin
          if (r_valid && r_ready) begin
            if (r.last) begin
              r_valid <= 1'b0;
              phase   <= 0;
            end else begin
              raddr   <= raddr + AXI_SIZE_BYTES;
              rcnt    <= rcnt - 1;
              r_valid <= go();
              r.data  <= mem[(raddr + AXI_SIZE_BYTES) / AXI_SIZE_BYTES];
              r.last  <= (rcnt == 1);
            end
          end else if (!r_valid) begin
            r_valid <= go();
            r.data  <= mem[raddr / AXI_SIZE_BYTES];
            r.last  <= (rcnt == 0);
          end
        end
        default: phase <= 0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* sim/mem_port_vectors.txt */
# op (1 write, 0 read), port, byte address (hex), len (beats minus one), data seed (hex)
# a second group of five fields on a line starts that burst together with the first
1 0 00000100 3 00001000
0 1 00000100 3 00000000
1 1 00000200 7 00002000 1 3 00000300 5 00003000
0 2 00000200 7 00000000 0 0 00000300 5 00000000
1 2 00000400 0 00004000 0 3 00000100 3 00000000
0 0 00000400 0 00000000
1 3 00000500 15 00005000
0 1 00000500 15 00000000
1 0 00000600 2 00006000 1 2 00000700 4 00007000
0 3 00000600 2 00000000 0 1 00000700 4 00000000
1 1 00000100 3 00008000
0 2 00000100 3 00000000 1 0 00000800 1 00009000
0 3 00000800 1 00000000

/* sim/tb_versat_mem_port.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_versat_mem_port import databus_pkg::*, axi_pkg::*;;

  logic                  clk;
  logic                  rst;
  db_req_t [N_PORTS-1:0] req;
  logic [N_PORTS-1:0]    port_ready;
  logic [N_PORTS-1:0]    port_last;
  logic [DATA_W-1:0]     rdata;
  axi_addr_t             aw;
  axi_addr_t             ar;
  axi_w_t                w;
  axi_r_t                r;
  logic                  aw_valid;
  logic                  aw_ready;
  logic                  ar_valid;
  logic                  ar_ready;
  logic                  w_valid;
  logic                  w_ready;
  logic                  r_valid;
  logic                  r_ready;
  logic                  b_valid;
  logic                  b_ready;

  int                v_cnt [64];   // Bursts per line
  int                v_op [64][2];
  int                v_port [64][2];
  int                v_addr [64][2];
  int                v_len [64][2];
  int                v_seed [64][2];
  int                n_lines;
  int                n_bursts;
  int                limit = 1000000;
  int                cyc = 0;
  int                start_cyc;
  bit                lat_pending;
  logic [N_PORTS-1:0] active = '0;
  logic [DATA_W-1:0] shadow [int];
  int                exp_kind[$];  // Expected AXI address order as 1 for write and 0 for read
  int                exp_addr[$];
  int                exp_len[$];
  int                exp_seed[$];
  int                flight = -1;  // Kind of the AXI burst in flight or -1
  int                cur_seed;
  int                cur_len;
  int                beat_idx;

  versat_mem_port versat_mem_port_inst (.*);

  axi_mem_model mem_model (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check(input string msg, input int got, input int exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    n;
    string s;
    fd = $fopen("sim/mem_port_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file");
      $display("Test FAILED");
      $fatal(1);
    end
    n_lines  = 0;
    n_bursts = 0;
    while ($fgets(s, fd) > 0) begin
      if (s.len() > 1 && s.getc(0) != "#") begin
        n = $sscanf(s, "%d %d %h %d %h %d %d %h %d %h",
          v_op[n_lines][0], v_port[n_lines][0], v_addr[n_lines][0],
          v_len[n_lines][0], v_seed[n_lines][0], v_op[n_lines][1],
          v_port[n_lines][1], v_addr[n_lines][1], v_len[n_lines][1],
          v_seed[n_lines][1]);
        v_cnt[n_lines] = (n >= 10) ? 2 : 1;
        n_bursts += v_cnt[n_lines];
        n_lines++;
      end
    end
    $fclose(fd);
  endtask

  task automatic expect_addr(input int l, input int b);
    exp_kind.push_back(v_op[l][b]);
    exp_addr.push_back(v_addr[l][b]);
    exp_len.push_back(v_len[l][b]);
    exp_seed.push_back(v_seed[l][b]);
  endtask

  // One unit driving a burst and checking what comes back at its port
  task automatic run_burst(input int p, input int op, input int addr,
                           input int len, input int seed);
    int beat;
    bit done;
    beat = 0;
    done = 0;
    @(posedge clk);
    #10;
    if (lat_pending) start_cyc = cyc;
    active[p]       = 1'b1;
    req[p].valid    = 1'b1;
    req[p].addr     = ADDR_W'(addr);
    req[p].len      = LEN_W'(len);
    req[p].wstrb    = op ? '1 : '0;
    req[p].wdata    = DATA_W'(seed);
    while (!done) begin
      @(negedge clk);
      if (port_ready[p]) begin
        if (op) shadow[addr / 4 + beat] = DATA_W'(seed + beat);
        else check("read data", int'(rdata), int'(shadow[addr / 4 + beat]));
        check("port_last", int'(port_last[p]), int'(beat == len));
        done = port_last[p];
        beat++;
      end
      @(posedge clk);
      #10;
      if (done) begin
        req[p].valid = 1'b0;
        active[p]    = 1'b0;
      end else begin
        req[p].wdata = DATA_W'(seed + beat);
      end
    end
  endtask

  task automatic take_addr(input int kind, input int addr, input int len);
    check("transaction already in flight", flight, -1);
    if (exp_kind.size() == 0) begin
      $display("Unexpected AXI address phase at %0t", $time);
      $display("Test FAILED");
      $fatal(1);
    end
    check("address kind", kind, exp_kind.pop_front());
    check("address", addr, exp_addr.pop_front());
    check("len", len, exp_len.pop_front());
    cur_seed = exp_seed.pop_front();
    cur_len  = len;
    beat_idx = 0;
    flight   = kind;
  endtask

  // AXI side monitor sampled mid-cycle
  always @(negedge clk) begin
    if (!rst && cyc > limit) begin
      $display("Run timed out after %0d cycles", limit);
      $display("Test FAILED");
      $fatal(1);
    end else if (!rst) begin
      check("port_ready without grant", int'(port_ready & ~active), 0);
      check("b_ready held high", int'(b_ready), 1);
      if (lat_pending && (aw_valid || ar_valid)) begin
        check("address latency", cyc - start_cyc, 2);
        lat_pending = 1'b0;
      end
      if (aw_valid && aw_ready) take_addr(1, int'(aw.addr), int'(aw.len));
      if (ar_valid && ar_ready) take_addr(0, int'(ar.addr), int'(ar.len));
      if (w_valid && w_ready) begin
        check("W beat outside a write", flight, 1);
        check("W data", int'(w.data), cur_seed + beat_idx);
        check("W strobe", int'(w.strb), (1 << STRB_W) - 1);
        check("W last", int'(w.last), int'(beat_idx == cur_len));
        if (w.last) flight = -1;
        beat_idx++;
      end
      if (r_valid && r_ready) begin
        check("R beat outside a read", flight, 0);
        if (r.last) flight = -1;
      end
    end
  end

  initial begin
    int f;
    void'($urandom(32'hef77));
    rst = 1'b1;
    req = '0;
    load_vectors();
    limit = 64 * n_bursts + 200;
    repeat (2) @(posedge clk);
    #10 rst = 1'b0;
    @(negedge clk);
    check("control low after reset",
      int'({aw_valid, ar_valid, w_valid, port_ready, port_last}), 0);
    for (int l = 0; l < n_lines; l++) begin
      lat_pending = (l == 0);
      if (v_cnt[l] == 1) begin
        expect_addr(l, 0);
        run_burst(v_port[l][0], v_op[l][0], v_addr[l][0], v_len[l][0], v_seed[l][0]);
      end else begin
        // Write first, then the higher port among equal kinds
        if (v_op[l][0] != v_op[l][1]) f = v_op[l][0] ? 0 : 1;
        else f = (v_port[l][0] > v_port[l][1]) ? 0 : 1;
        expect_addr(l, f);
        expect_addr(l, 1 - f);
        fork
          run_burst(v_port[l][0], v_op[l][0], v_addr[l][0], v_len[l][0], v_seed[l][0]);
          run_burst(v_port[l][1], v_op[l][1], v_addr[l][1], v_len[l][1], v_seed[l][1]);
        join
      end
    end
    wait (flight == -1);
    check("AXI bursts never started", exp_kind.size(), 0);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* versat_mem_port.f */
rtl/databus_pkg.sv
rtl/axi_pkg.sv
rtl/skid_slice.sv
rtl/databus_merge.sv
rtl/axi_burst_master.sv
rtl/versat_mem_port.sv
sim/axi_mem_model.sv
sim/tb_versat_mem_port.sv
